// File: uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Serial byte width
`define UART_DATA_W      8

// Receive FIFO entries as a power of two (4, 8 or 16)
`define UART_FIFO_DEPTH  4

// Clocks per serial bit out of reset
`define UART_BAUD_RESET  16'd16

// Wishbone word addresses
`define UART_ADDR_TX     2'd0  // Transmit byte
`define UART_ADDR_RX     2'd1  // Receive byte that pops the FIFO
`define UART_ADDR_STATUS 2'd2  // Flags with W1C on bits 3 and 4
`define UART_ADDR_BAUD   2'd3  // Divisor

`endif

// File: uart_pkg.sv
`include "uart_params.svh"

package uart_pkg;

	// Widths with a meaning of their own
	typedef logic [`UART_DATA_W-1:0] uart_byte_t; // One serial byte
	typedef logic [15:0] baud_div_t;              // Clocks per bit
	typedef logic [15:0] wb_data_t;               // Bus data word
	typedef logic [1:0]  wb_addr_t;               // Bus word address

	// Receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE, RX_START, RX_DATA, RX_STOP
	} rx_state_t;

	// Transmitter FSM
	typedef enum logic [1:0] {
		TX_IDLE, TX_START, TX_DATA, TX_STOP
	} tx_state_t;

endpackage

// File: uart_rx_fifo.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx_fifo
	import uart_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       push,
	input  uart_byte_t push_data,
	input  logic       pop,
	output uart_byte_t head,      // Oldest byte when not empty
	output logic       empty,
	output logic       full,
	output logic       overrun    // Pulse when a pushed byte is dropped
);

	localparam int DEPTH = `UART_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	uart_byte_t       mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;     // Pointers wrap on their own as depth is a power of two
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	assign empty   = (count == 0);
	assign full    = (count == DEPTH);
	assign do_pop  = pop && !empty;
	assign do_push = push && (!full || do_pop);  // Full plus pop still takes the byte
	assign head    = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			overrun <= 1'b0;
		end else begin
			overrun <= push && !do_push;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

// File: uart_core.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_core
	import uart_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  baud_div_t  baud_div,   // Shared by both directions
	input  logic       tx_start,   // One-cycle request honoured when idle
	input  uart_byte_t tx_data,
	output logic       tx,
	output logic       tx_empty,
	input  logic       rx,         // Asynchronous line
	output uart_byte_t rx_data,
	output logic       rx_valid,
	output logic       frame_err
);

	localparam int BIT_W    = $clog2(`UART_DATA_W);
	localparam int LAST_BIT = `UART_DATA_W - 1;

	// Transmit side
	tx_state_t        tx_state;
	baud_div_t        tx_baud_cnt;
	logic [BIT_W-1:0] tx_bit_cnt;
	uart_byte_t       tx_shreg;
	logic             tx_bit_end;
	logic             tx_load;
	logic             tx_shift;

	// Receive side
	rx_state_t        rx_state;
	baud_div_t        rx_baud_cnt;
	logic [BIT_W-1:0] rx_bit_cnt;
	uart_byte_t       rx_shreg;
	logic             rx_d1;
	logic             rx_d2;
	logic             rx_err_hold;  // Set by a bad stop bit until the line is high
	baud_div_t        half_div;
	logic             rx_half_end;
	logic             rx_bit_end;
	logic             rx_shift;
	logic             rx_stop_ok;

	// ----------------------------------------------------------------------
	// Transmitter
	// ----------------------------------------------------------------------
	assign tx_bit_end = (tx_baud_cnt == baud_div - 1'b1);
	assign tx_load    = (tx_state == TX_IDLE) && tx_start;
	assign tx_shift   = (tx_state == TX_DATA) && tx_bit_end;

	// Byte captured at start so later tx_data changes are ignored
	always_ff @(posedge clk) begin
		if (tx_load)
			tx_shreg <= tx_data;
		else if (tx_shift)
			tx_shreg <= tx_shreg >> 1;  // LSB first
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_state    <= TX_IDLE;
			tx          <= 1'b1;  // Idle line
			tx_empty    <= 1'b1;
			tx_baud_cnt <= '0;
			tx_bit_cnt  <= '0;
		end else begin
			if (tx_state == TX_IDLE || tx_bit_end)
				tx_baud_cnt <= '0;
			else
				tx_baud_cnt <= tx_baud_cnt + 1'b1;

			case (tx_state)
				TX_IDLE: if (tx_start) begin
					tx_state <= TX_START;
					tx       <= 1'b0;      // Start bit begins now
					tx_empty <= 1'b0;
				end
				TX_START: if (tx_bit_end) begin
					tx_state   <= TX_DATA;
					tx         <= tx_shreg[0];
					tx_bit_cnt <= '0;
				end
				TX_DATA: if (tx_bit_end) begin
					if (tx_bit_cnt == LAST_BIT) begin
						tx_state <= TX_STOP;
						tx       <= 1'b1;  // Stop bit
					end else begin
						tx         <= tx_shreg[1];  // Next bit as shreg shifts this edge
						tx_bit_cnt <= tx_bit_cnt + 1'b1;
					end
				end
				TX_STOP: if (tx_bit_end) begin
					tx_state <= TX_IDLE;
					tx_empty <= 1'b1;      // 10 bit times after it fell
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Receiver sampling at mid-bit
	// ----------------------------------------------------------------------
	assign half_div    = baud_div >> 1;
	assign rx_half_end = (rx_baud_cnt == half_div - 1'b1);
	assign rx_bit_end  = (rx_baud_cnt == baud_div - 1'b1);
	assign rx_shift    = (rx_state == RX_DATA) && rx_bit_end;
	assign rx_stop_ok  = (rx_state == RX_STOP) && !rx_err_hold && rx_bit_end && rx_d2;

	always_ff @(posedge clk) begin
		if (rx_shift)
			rx_shreg <= {rx_d2, rx_shreg[LAST_BIT:1]};
		if (rx_stop_ok)
			rx_data <= rx_shreg;  // Only on a good frame
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_d1       <= 1'b1;
			rx_d2       <= 1'b1;
			rx_state    <= RX_IDLE;
			rx_baud_cnt <= '0;
			rx_bit_cnt  <= '0;
			rx_err_hold <= 1'b0;
			rx_valid    <= 1'b0;
			frame_err   <= 1'b0;
		end else begin
			rx_d1     <= rx;     // Two-flop synchronizer
			rx_d2     <= rx_d1;
			rx_valid  <= 1'b0;
			frame_err <= 1'b0;

			// Restart count at start detect, half bit and every full bit
			if (rx_state == RX_IDLE || (rx_state == RX_START && rx_half_end) || rx_bit_end)
				rx_baud_cnt <= '0;
			else
				rx_baud_cnt <= rx_baud_cnt + 1'b1;

			case (rx_state)
				RX_IDLE: if (!rx_d2)
					rx_state <= RX_START;
				RX_START: if (rx_half_end) begin
					if (rx_d2) begin
						rx_state <= RX_IDLE;  // Glitch rather than a start bit
					end else begin
						rx_state   <= RX_DATA;
						rx_bit_cnt <= '0;
					end
				end
				RX_DATA: if (rx_bit_end) begin
					if (rx_bit_cnt == LAST_BIT)
						rx_state <= RX_STOP;
					else
						rx_bit_cnt <= rx_bit_cnt + 1'b1;
				end
				RX_STOP: begin
					if (rx_err_hold) begin
						if (rx_d2) begin
							rx_err_hold <= 1'b0;
							rx_state    <= RX_IDLE;
						end
					end else if (rx_bit_end) begin
						if (rx_d2) begin
							rx_valid <= 1'b1;
							rx_state <= RX_IDLE;
						end else begin
							frame_err   <= 1'b1;  // Byte discarded
							rx_err_hold <= 1'b1;
						end
					end
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

endmodule

// File: uart_wb_regs.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_wb_regs
	import uart_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	// Wishbone classic slave
	input  logic       cyc,
	input  logic       stb,
	input  logic       we,
	input  wb_addr_t   adr,
	input  wb_data_t   dat_w,
	output wb_data_t   dat_r,
	output logic       ack,
	// Core side
	output baud_div_t  baud_div,
	output logic       tx_start,
	output uart_byte_t tx_data,
	input  logic       tx_empty,
	input  logic       frame_err,
	// FIFO side
	input  uart_byte_t fifo_head,
	input  logic       fifo_empty,
	input  logic       fifo_full,
	input  logic       fifo_overrun,
	output logic       fifo_pop
);

	logic      req;
	logic      req_q;          // Request seen last cycle
	logic      acc;            // Access accepted with ack on the next cycle
	logic      wr_acc;
	logic      rd_acc;
	baud_div_t baud_q;
	logic      overrun_flag;   // Sticky
	logic      frame_err_flag; // Sticky
	wb_data_t  status;

	// ----------------------------------------------------------------------
	// Bus decode
	// ----------------------------------------------------------------------
	assign req    = cyc && stb;
	assign acc    = req && !req_q;  // Rising edge of the request only
	assign wr_acc = acc && we;
	assign rd_acc = acc && !we;

	always_ff @(posedge clk) begin
		if (reset) begin
			req_q <= 1'b0;
			ack   <= 1'b0;
		end else begin
			req_q <= req;   // Stays high until stb drops so one ack per request
			ack   <= acc;
		end
	end

	// Strobes to core and FIFO on the edge that raises ack
	assign tx_data  = dat_w[`UART_DATA_W-1:0];
	assign tx_start = wr_acc && (adr == `UART_ADDR_TX) && tx_empty;  // Busy TX drops write
	assign fifo_pop = rd_acc && (adr == `UART_ADDR_RX) && !fifo_empty;
	assign baud_div = baud_q;

	// Bit 0 tx_empty, 1 rx_avail, 2 rx_full, 3 overrun, 4 frame_err
	assign status = wb_data_t'({frame_err_flag, overrun_flag, fifo_full, !fifo_empty,
		tx_empty});

	// ----------------------------------------------------------------------
	// Read data held while ack is high
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rd_acc) begin
			case (adr)
				`UART_ADDR_RX:     dat_r <= fifo_empty ? '0 : wb_data_t'(fifo_head);
				`UART_ADDR_STATUS: dat_r <= status;
				`UART_ADDR_BAUD:   dat_r <= baud_q;
				default:           dat_r <= '0;  // TX reads as zero
			endcase
		end else if (wr_acc) begin
			dat_r <= '0;
		end
	end

	// ----------------------------------------------------------------------
	// Divisor and sticky flags
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			baud_q         <= `UART_BAUD_RESET;
			overrun_flag   <= 1'b0;
			frame_err_flag <= 1'b0;
		end else begin
			if (wr_acc && adr == `UART_ADDR_BAUD)
				baud_q <= dat_w;

			// New event wins over a clear in the same cycle
			if (fifo_overrun)
				overrun_flag <= 1'b1;
			else if (wr_acc && adr == `UART_ADDR_STATUS && dat_w[3])
				overrun_flag <= 1'b0;

			if (frame_err)
				frame_err_flag <= 1'b1;
			else if (wr_acc && adr == `UART_ADDR_STATUS && dat_w[4])
				frame_err_flag <= 1'b0;
		end
	end

endmodule

// File: uart_top.sv
`timescale 1ns/1ps

module uart_top
	import uart_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     cyc,
	input  logic     stb,
	input  logic     we,
	input  wb_addr_t adr,
	input  wb_data_t dat_w,
	output wb_data_t dat_r,
	output logic     ack,
	input  logic     rx,   // Serial in
	output logic     tx    // Serial out
);

	// Regs to core
	baud_div_t  baud_div;
	logic       tx_start;
	uart_byte_t tx_data;
	logic       tx_empty;
	logic       frame_err;

	// Core to FIFO as a straight push
	logic       rx_valid;
	uart_byte_t rx_data;

	// FIFO to regs
	uart_byte_t fifo_head;
	logic       fifo_empty;
	logic       fifo_full;
	logic       fifo_overrun;
	logic       fifo_pop;

	uart_wb_regs u_regs (
		.clk(clk), .reset(reset),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
		.baud_div(baud_div), .tx_start(tx_start), .tx_data(tx_data),
		.tx_empty(tx_empty), .frame_err(frame_err),
		.fifo_head(fifo_head), .fifo_empty(fifo_empty), .fifo_full(fifo_full),
		.fifo_overrun(fifo_overrun), .fifo_pop(fifo_pop)
	);

	uart_core u_core (
		.clk(clk), .reset(reset), .baud_div(baud_div),
		.tx_start(tx_start), .tx_data(tx_data), .tx(tx), .tx_empty(tx_empty),
		.rx(rx), .rx_data(rx_data), .rx_valid(rx_valid), .frame_err(frame_err)
	);

	uart_rx_fifo u_fifo (
		.clk(clk), .reset(reset),
		.push(rx_valid), .push_data(rx_data), .pop(fifo_pop),
		.head(fifo_head), .empty(fifo_empty), .full(fifo_full), .overrun(fifo_overrun)
	);

endmodule

// File: uart_tb.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tb
	import uart_pkg::*;
();

	localparam int BIT_CYC   = 8;     // Divisor programmed in test 2
	localparam int CYC_LIMIT = 6000;  // About 40 frames of 80 cycles plus margin
	localparam int ACK_MAX   = 16;    // Cycles to wait for ack
	localparam int POLL_MAX  = 200;   // STATUS polls before giving up

	logic       clk;
	logic       reset;
	logic       cyc;
	logic       stb;
	logic       we;
	wb_addr_t   adr;
	wb_data_t   dat_w;
	wb_data_t   dat_r;
	logic       ack;
	logic       rx_line;
	logic       tx_line;
	logic       loop_sel;             // High feeds tx back into rx
	logic       bang_rx;              // Driven line when not looped

	int         seed;
	int         errors = 0;
	int         cycles = 0;
	int         req_cnt = 0;
	int         ack_cnt = 0;
	int         tests_passed = 0;
	int         tests_failed = 0;
	uart_byte_t sent_q[$];            // Bytes in expected receive order

	uart_top u_dut (
		.clk(clk), .reset(reset),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
		.rx(rx_line), .tx(tx_line)
	);

	assign rx_line = loop_sel ? tx_line : bang_rx;  // Loopback or bit-banged frames

	initial clk = 1'b0;
	always #50 clk = ~clk;  // 100 ns period

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYC_LIMIT) begin
			$display("Run stopped, cycle limit of %0d reached", CYC_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	always @(negedge clk)
		if (!reset && ack)
			ack_cnt++;  // Compared with req_cnt at the end

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------
	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp)
		else begin
			$display("Fail %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	// One Wishbone classic access with read data taken while ack is high
	task automatic bus_access(input logic write, input wb_addr_t a, input wb_data_t d,
		output wb_data_t rd);
		int n;
		n = 0;
		req_cnt++;
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= write;
		adr   <= a;
		dat_w <= d;
		do begin
			@(negedge clk);
			n++;
		end while (!ack && n < ACK_MAX);
		assert (ack)
		else begin
			$display("No ack from the slave for address %0d", a);
			errors++;
		end
		rd = dat_r;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
		@(negedge clk);
		assert (!ack)  // Ack lasts one cycle
		else begin
			$display("Ack stayed high for more than one cycle at address %0d", a);
			errors++;
		end
	endtask

	task automatic bus_write(input wb_addr_t a, input wb_data_t d);
		wb_data_t unused;
		bus_access(1'b1, a, d, unused);
	endtask

	task automatic bus_read(input wb_addr_t a, output wb_data_t d);
		bus_access(1'b0, a, '0, d);
	endtask

	// Poll STATUS until the masked bits match
	task automatic wait_status(input wb_data_t mask, input wb_data_t value, input string what);
		wb_data_t s;
		int       n;
		n = 0;
		do begin
			bus_read(`UART_ADDR_STATUS, s);
			n++;
		end while ((s & mask) != value && n < POLL_MAX);
		assert ((s & mask) == value)
		else begin
			$display("Gave up waiting for %s, frame appears hung", what);
			errors++;
		end
	endtask

	// 8N1 frame on bang_rx with the stop bit chosen by the caller
	task automatic send_frame(input uart_byte_t b, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			bang_rx <= bits[i];  // LSB first after start
			repeat (BIT_CYC - 1) @(posedge clk);
		end
		@(posedge clk);
		bang_rx <= 1'b1;  // Back to idle
	endtask

	// Watch tx and sample each bit near its middle
	task automatic capture_frame(output uart_byte_t b, output logic start_bit,
		output logic stop_bit);
		int n;
		n = 0;
		b = '0;
		do begin
			@(negedge clk);
			n++;
		end while (tx_line && n < 40);
		assert (!tx_line)
		else begin
			$display("No start bit seen on tx");
			errors++;
		end
		repeat (BIT_CYC / 2 - 1) @(negedge clk);
		start_bit = tx_line;
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CYC) @(negedge clk);
			b[i] = tx_line;
		end
		repeat (BIT_CYC) @(negedge clk);
		stop_bit = tx_line;
	endtask

	task automatic finish_test(input int num, input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_passed++;
			$display("Test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", num, name, errors - errs_before);
		end
	endtask

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------
	initial begin
		wb_data_t   d;
		uart_byte_t b;
		uart_byte_t got;
		logic       start_bit;
		logic       stop_bit;
		int         e0;

		seed     = 72790;
		reset    <= 1'b1;
		cyc      <= 1'b0;
		stb      <= 1'b0;
		we       <= 1'b0;
		adr      <= '0;
		dat_w    <= '0;
		loop_sel <= 1'b0;
		bang_rx  <= 1'b1;  // Idle line
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Reset values
		e0 = errors;
		bus_read(`UART_ADDR_STATUS, d);
		check_value("status", d, 16'h0001);  // tx_empty only
		bus_read(`UART_ADDR_BAUD, d);
		check_value("baud_div", d, `UART_BAUD_RESET);
		@(negedge clk);
		check_value("tx", tx_line, 1'b1);
		bus_read(`UART_ADDR_RX, d);
		check_value("rx_data", d, 16'h0000);  // Empty FIFO
		finish_test(1, "reset values", e0);

		e0 = errors;
		bus_write(`UART_ADDR_BAUD, 16'(BIT_CYC));
		bus_read(`UART_ADDR_BAUD, d);
		check_value("baud_div", d, 16'(BIT_CYC));
		finish_test(2, "divisor write", e0);

		// Frame on tx with the rx line held idle
		e0 = errors;
		b  = uart_byte_t'($random(seed));
		fork
			capture_frame(got, start_bit, stop_bit);
			begin
				bus_write(`UART_ADDR_TX, b);
				bus_read(`UART_ADDR_STATUS, d);
				check_value("status", d, 16'h0000);  // Busy
				bus_write(`UART_ADDR_TX, ~b);         // Ignored mid-frame
			end
		join
		check_value("tx_start_bit", start_bit, 1'b0);
		check_value("tx_data", got, b);
		check_value("tx_stop_bit", stop_bit, 1'b1);
		wait_status(16'h0001, 16'h0001, "tx_empty");
		finish_test(3, "transmit frame", e0);

		e0 = errors;
		@(posedge clk);
		loop_sel <= 1'b1;
		for (int i = 0; i < 3; i++) begin
			b = uart_byte_t'($random(seed));
			sent_q.push_back(b);
			bus_write(`UART_ADDR_TX, b);
			wait_status(16'h0001, 16'h0001, "tx_empty");
		end
		while (sent_q.size() > 0) begin
			wait_status(16'h0002, 16'h0002, "rx_avail");
			bus_read(`UART_ADDR_RX, d);
			check_value("rx_data", d, sent_q.pop_front());
		end
		bus_read(`UART_ADDR_STATUS, d);
		check_value("rx_avail", d[1], 1'b0);
		finish_test(4, "loopback", e0);

		// Low stop bit
		e0 = errors;
		@(posedge clk);
		loop_sel <= 1'b0;
		send_frame(uart_byte_t'($random(seed)), 1'b0);
		wait_status(16'h0010, 16'h0010, "frame_err");
		bus_read(`UART_ADDR_STATUS, d);
		check_value("status", d, 16'h0011);  // No byte kept
		bus_write(`UART_ADDR_STATUS, 16'h0010);
		bus_read(`UART_ADDR_STATUS, d);
		check_value("status", d, 16'h0001);
		finish_test(5, "frame error", e0);

		// Five bytes into a four-entry FIFO
		e0 = errors;
		@(posedge clk);
		loop_sel <= 1'b1;
		for (int i = 0; i < 5; i++) begin
			b = uart_byte_t'($random(seed));
			sent_q.push_back(b);
			bus_write(`UART_ADDR_TX, b);
			wait_status(16'h0001, 16'h0001, "tx_empty");
		end
		wait_status(16'h0009, 16'h0009, "overrun");
		bus_read(`UART_ADDR_STATUS, d);
		check_value("status", d, 16'h000F);
		for (int i = 0; i < 4; i++) begin
			bus_read(`UART_ADDR_RX, d);
			check_value("rx_data", d, sent_q.pop_front());
		end
		bus_read(`UART_ADDR_STATUS, d);
		check_value("status", d, 16'h0009);  // Drained with overrun still set
		bus_write(`UART_ADDR_STATUS, 16'h0008);
		bus_read(`UART_ADDR_STATUS, d);
		check_value("status", d, 16'h0001);
		check_value("ack_count", 16'(ack_cnt), 16'(req_cnt));
		finish_test(6, "fifo overrun", e0);

		$display("Tests passed %0d failed %0d", tests_passed, tests_failed);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+.
uart_pkg.sv
uart_rx_fifo.sv
uart_core.sv
uart_wb_regs.sv
uart_top.sv
uart_tb.sv
